// ==== Bender.yml ====
package:
  name: cpu

sources:
  - src/cpu_pkg.sv
  - src/fetch_unit.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/writeback_unit.sv
  - src/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_tb.sv

// ==== files.f ====
src/cpu_pkg.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/writeback_unit.sv
src/cpu_top.sv
sim/cpu_tb.sv

// ==== sim/cpu_tb.sv ====
/*
 * cpu_tb
 * random forward-branching program, instruction memory and reference model
 * for the single-cycle register machine
 */
module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 3;
   localparam int max_cycles   = 300; // watchdog budget
   localparam int run_limit    = 280;
   localparam int stop_cycles  = 20;  // cycles watched once stop is reached

   logic            clk;
   logic            reset;
   cpu_pkg::instr_t code;
   cpu_pkg::pc_t    pc;
   cpu_pkg::pc_t    next_pc;
   cpu_pkg::word_t  result;
   logic            write_en;
   logic            imm_en;
   logic            branch_en;

   cpu_pkg::instr_t prog [256];
   cpu_pkg::word_t  model_regs [16];
   cpu_pkg::pc_t    model_pc;
   cpu_pkg::pc_t    stop_addr;
   integer          seed = 32'hf63c6974;
   int              pc_errors;
   int              word_errors;
   int              flag_errors;

   cpu_top u_dut (
      .clk, .reset, .code, .pc, .next_pc, .result, .write_en, .imm_en, .branch_en
   );

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   task automatic check_pc(input string name, input cpu_pkg::pc_t expected,
                           input cpu_pkg::pc_t actual);
      if (actual !== expected) begin
         pc_errors++;
         $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic check_word(input string name, input cpu_pkg::word_t expected,
                             input cpu_pkg::word_t actual);
      if (actual !== expected) begin
         word_errors++;
         $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         flag_errors++;
         $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   function automatic cpu_pkg::word_t alu_model(input cpu_pkg::alu_op_e op,
                                                input cpu_pkg::word_t a,
                                                input cpu_pkg::word_t b);
      case (op)
         cpu_pkg::alu_sll: return a << b[4:0];
         cpu_pkg::alu_srl: return a >> b[4:0];
         cpu_pkg::alu_add: return a + b;
         cpu_pkg::alu_sub: return a - b;
         cpu_pkg::alu_and: return a & b;
         default:          return ~(a ^ b);
      endcase
   endfunction

   // jumps only go forward, so every run reaches the stop
   task automatic build_program();
      logic [31:0] r;
      logic [7:0]  imm;
      int          kind;
      int          target;
      stop_addr = cpu_pkg::pc_t'(201 + $unsigned($random(seed)) % 50);
      for (int i = 0; i < 256; i++) begin
         r    = $unsigned($random(seed));
         imm  = (r[1:0] == 2'b00) ? 8'h00 : r[9:2]; // zeros feed the jz/jnz tests
         kind = $unsigned($random(seed)) % 8;
         if (i < 16) begin
            prog[i] = {cpu_pkg::op_loadi, 4'(i), imm};
         end else if (i == stop_addr) begin
            prog[i] = {cpu_pkg::op_stop, 12'h000};
         end else if (kind < 4 || i > stop_addr) begin
            prog[i] = {1'b0, 3'($unsigned($random(seed)) % 6), r[21:10]};
         end else if (kind < 6) begin
            prog[i] = {cpu_pkg::op_loadi, r[13:10], imm};
         end else begin
            target  = i + 1 + int'($unsigned($random(seed)) % (stop_addr - i));
            prog[i] = {(kind == 6) ? cpu_pkg::op_jz : cpu_pkg::op_jnz,
                       4'(target >> 4), r[13:10], 4'(target)};
         end
      end
   endtask

   initial begin
      cpu_pkg::instr_t instr;
      cpu_pkg::pc_t    exp_next;
      cpu_pkg::word_t  exp_result;
      logic            exp_write;
      logic            exp_imm;
      logic            exp_branch;
      logic            a_zero;
      int              cycle;
      int              after_stop;
      pc_errors   = 0;
      word_errors = 0;
      flag_errors = 0;
      build_program();
      code  = prog[0];
      reset = 1'b1;
      repeat (reset_cycles) @(negedge clk);
      check_pc("next_pc", '0, next_pc); // held at zero under reset
      reset      = 1'b0;
      model_pc   = '0;
      cycle      = 0;
      after_stop = 0;
      while (cycle < run_limit && after_stop < stop_cycles) begin
         if (cycle > 0) @(negedge clk);
         check_pc("pc", model_pc, pc);
         code  = prog[pc];
         instr = prog[model_pc];
         #5; // let the combinational path settle
         a_zero     = (model_regs[instr[7:4]][7:0] == 8'd0);
         exp_next   = cpu_pkg::pc_t'(model_pc + 8'd1);
         exp_result = '0;
         exp_write  = 1'b0;
         exp_imm    = 1'b0;
         exp_branch = 1'b0;
         if (!instr[15]) begin
            exp_result = alu_model(cpu_pkg::alu_op_e'(instr[14:12]),
                                   model_regs[instr[7:4]], model_regs[instr[3:0]]);
            exp_write  = 1'b1;
         end else begin
            case (instr[15:12])
               cpu_pkg::op_loadi: begin
                  exp_result = cpu_pkg::word_t'(instr[7:0]);
                  exp_write  = 1'b1;
                  exp_imm    = 1'b1;
               end
               cpu_pkg::op_jz:   exp_branch = a_zero;
               cpu_pkg::op_jnz:  exp_branch = !a_zero;
               cpu_pkg::op_stop: exp_next   = model_pc;
               default: ;
            endcase
         end
         if (exp_branch) exp_next = {instr[11:8], instr[3:0]};
         check_flag("write_en", exp_write, write_en);
         check_flag("imm_en", exp_imm, imm_en);
         check_flag("branch_en", exp_branch, branch_en);
         check_pc("next_pc", exp_next, next_pc);
         if (exp_write) begin
            check_word("result", exp_result, result);
            model_regs[instr[11:8]] = exp_result;
         end
         if (instr[15:12] == cpu_pkg::op_stop) after_stop++;
         model_pc = exp_next;
         cycle++;
      end
      if (after_stop == 0) begin
         flag_errors++;
         $display("program never reached the stop instruction at %0d", stop_addr);
      end
      $display("errors: pc %0d, word %0d, flag %0d", pc_errors, word_errors, flag_errors);
      if (pc_errors + word_errors + flag_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #((max_cycles + reset_cycles) * clk_period);
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== src/alu.sv ====
/*
 * alu
 * logical shifts, shared add/subtract, bitwise and and xnor
 */
module alu #(
   parameter int data_width = cpu_pkg::data_width
) (
   input  logic [data_width-1:0]  a,
   input  logic [data_width-1:0]  b,
   input  cpu_pkg::alu_op_e       alu_op,
   output logic [data_width-1:0]  alu_result
);

   localparam int shamt_width = $clog2(data_width);

   logic [shamt_width-1:0] shamt;
   logic                   sub;
   logic [data_width-1:0]  b_inv;
   logic [data_width-1:0]  sum;

   assign shamt = b[shamt_width-1:0]; // low 5 bits at 32

   // one adder, b inverted plus carry in for subtract
   assign sub   = (alu_op == cpu_pkg::alu_sub);
   assign b_inv = b ^ {data_width{sub}};
   assign sum   = a + b_inv + data_width'(sub);

   always_comb begin
      case (alu_op)
         cpu_pkg::alu_sll:  alu_result = a << shamt;
         cpu_pkg::alu_srl:  alu_result = a >> shamt;
         cpu_pkg::alu_add,
         cpu_pkg::alu_sub:  alu_result = sum;
         cpu_pkg::alu_and:  alu_result = a & b;
         cpu_pkg::alu_xnor: alu_result = ~(a ^ b);
         default:           alu_result = '0; // reserved
      endcase
   end

   // decoder maps non-alu instructions to add, so a reserved code here
   // means an alu instruction used 110 or 111
   always_comb begin
      assert final ($isunknown(alu_op) ||
                    alu_op inside {cpu_pkg::alu_sll, cpu_pkg::alu_srl,
                                   cpu_pkg::alu_add, cpu_pkg::alu_sub,
                                   cpu_pkg::alu_and, cpu_pkg::alu_xnor})
         else $error("reserved alu code %b", alu_op);
   end

endmodule

// ==== src/cpu_pkg.sv ====
/*
 * cpu_pkg
 * widths, types and instruction encodings shared by the 32-bit register machine
 */
package cpu_pkg;

   localparam int data_width  = 32;
   localparam int pc_width    = 8;
   localparam int reg_count   = 16;
   localparam int instr_width = 16;

   typedef logic [data_width-1:0]         word_t;
   typedef logic [pc_width-1:0]           pc_t;
   typedef logic [$clog2(reg_count)-1:0]  reg_addr_t;
   typedef logic [instr_width-1:0]        instr_t;

   // alu function field, bits 14..12 of an alu instruction
   // 3'b110 and 3'b111 were the divider and are reserved
   typedef enum logic [2:0] {
      alu_sll  = 3'b000,
      alu_srl  = 3'b001,
      alu_add  = 3'b010,
      alu_sub  = 3'b011,
      alu_and  = 3'b100,
      alu_xnor = 3'b101
   } alu_op_e;

   // opcode in bits 15..12, bit 15 clear means an alu instruction
   //   alu   : 0 op[2:0] s a b
   //   loadi : 1010 s imm[7:0]
   //   jz    : 1000 pc[7:4] a pc[3:0]
   //   jnz   : 1001 pc[7:4] a pc[3:0]
   //   stop  : 1111 xxxx xxxx xxxx
   localparam logic [3:0] op_jz    = 4'b1000;
   localparam logic [3:0] op_jnz   = 4'b1001;
   localparam logic [3:0] op_loadi = 4'b1010;
   localparam logic [3:0] op_stop  = 4'b1111;

endpackage

// ==== src/cpu_top.sv ====
/*
 * cpu_top
 * single-cycle 32-bit register machine, instruction memory sits outside
 */
module cpu_top (
   input  logic             clk,
   input  logic             reset,
   input  cpu_pkg::instr_t  code,
   output cpu_pkg::pc_t     pc,
   output cpu_pkg::pc_t     next_pc,
   output cpu_pkg::word_t   result,
   output logic             write_en,
   output logic             imm_en,
   output logic             branch_en
);

   localparam int data_width = cpu_pkg::data_width;
   localparam int reg_count  = cpu_pkg::reg_count;

   cpu_pkg::alu_op_e   alu_op;
   cpu_pkg::reg_addr_t addr_s;
   cpu_pkg::reg_addr_t addr_a;
   cpu_pkg::reg_addr_t addr_b;
   cpu_pkg::word_t     imm;
   cpu_pkg::pc_t       branch_pc;
   logic               jz_en;
   logic               jnz_en;
   logic               stop_en;
   cpu_pkg::word_t     rd_a;
   cpu_pkg::word_t     rd_b;
   cpu_pkg::word_t     alu_result;

   fetch_unit u_fetch (
      .clk, .reset, .branch_en, .branch_pc, .stop_en, .pc, .next_pc
   );

   instr_decoder u_decode (
      .code, .alu_op, .addr_s, .addr_a, .addr_b, .imm, .branch_pc,
      .write_en, .imm_en, .jz_en, .jnz_en, .stop_en
   );

   reg_file #(.data_width(data_width), .reg_count(reg_count)) u_regs (
      .clk, .write_en, .addr_s, .addr_a, .addr_b,
      .wr_data(result), .rd_a, .rd_b
   );

   alu #(.data_width(data_width)) u_alu (
      .a(rd_a), .b(rd_b), .alu_op, .alu_result
   );

   writeback_unit #(.data_width(data_width)) u_wb (
      .rd_a, .alu_result, .imm, .imm_en, .jz_en, .jnz_en, .branch_en, .result
   );

endmodule

// ==== src/fetch_unit.sv ====
/*
 * fetch_unit
 * program counter, picks reset, hold, branch target or increment
 */
module fetch_unit (
   input  logic            clk,
   input  logic            reset,
   input  logic            branch_en,
   input  cpu_pkg::pc_t    branch_pc,
   input  logic            stop_en,
   output cpu_pkg::pc_t    pc,
   output cpu_pkg::pc_t    next_pc
);

   cpu_pkg::pc_t inc_pc;

   assign inc_pc = pc + cpu_pkg::pc_t'(1); // wraps at 255

   always_comb begin
      if (reset) begin
         next_pc = '0;
      end else if (stop_en) begin
         next_pc = pc; // stop holds until reset
      end else if (branch_en) begin
         next_pc = branch_pc;
      end else begin
         next_pc = inc_pc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else begin
         pc <= next_pc;
      end
   end

   // stop comes from the decoder, branch from the writeback test
   assert property (@(posedge clk) disable iff (reset) !(branch_en && stop_en))
      else $error("branch and stop asserted in the same cycle");

endmodule

// ==== src/instr_decoder.sv ====
/*
 * instr_decoder
 * splits a 16-bit instruction into register fields, immediate and enables
 */
module instr_decoder (
   input  cpu_pkg::instr_t    code,
   output cpu_pkg::alu_op_e   alu_op,
   output cpu_pkg::reg_addr_t addr_s,
   output cpu_pkg::reg_addr_t addr_a,
   output cpu_pkg::reg_addr_t addr_b,
   output cpu_pkg::word_t     imm,
   output cpu_pkg::pc_t       branch_pc,
   output logic               write_en,
   output logic               imm_en,
   output logic               jz_en,
   output logic               jnz_en,
   output logic               stop_en
);

   logic [3:0] opcode;
   logic       alu_instr;

   assign opcode    = code[15:12];
   assign alu_instr = ~code[15];

   // non-alu instructions present add so the alu never sees a reserved code
   assign alu_op = alu_instr ? cpu_pkg::alu_op_e'(code[14:12]) : cpu_pkg::alu_add;

   assign addr_s = code[11:8];
   assign addr_a = code[7:4];    // also the register tested by jz/jnz
   assign addr_b = code[3:0];

   assign imm       = cpu_pkg::word_t'(code[7:0]); // zero extended
   assign branch_pc = {code[11:8], code[3:0]};

   always_comb begin
      imm_en  = 1'b0;
      jz_en   = 1'b0;
      jnz_en  = 1'b0;
      stop_en = 1'b0;
      case (opcode)
         cpu_pkg::op_loadi: imm_en  = 1'b1;
         cpu_pkg::op_jz:    jz_en   = 1'b1;
         cpu_pkg::op_jnz:   jnz_en  = 1'b1;
         cpu_pkg::op_stop:  stop_en = 1'b1;
         default: ;
      endcase
   end

   assign write_en = alu_instr | imm_en;

endmodule

// ==== src/reg_file.sv ====
/*
 * reg_file
 * register array with two combinational read ports and one clocked write port
 */
module reg_file #(
   parameter int data_width = cpu_pkg::data_width,
   parameter int reg_count  = cpu_pkg::reg_count
) (
   input  logic                          clk,
   input  logic                          write_en,
   input  logic [$clog2(reg_count)-1:0]  addr_s,
   input  logic [$clog2(reg_count)-1:0]  addr_a,
   input  logic [$clog2(reg_count)-1:0]  addr_b,
   input  logic [data_width-1:0]         wr_data,
   output logic [data_width-1:0]         rd_a,
   output logic [data_width-1:0]         rd_b
);

   logic [data_width-1:0] regs [reg_count];

   always_ff @(posedge clk) begin
      if (write_en) begin
         regs[addr_s] <= wr_data;
      end
   end

   // new value visible on the cycle after the write
   assign rd_a = regs[addr_a];
   assign rd_b = regs[addr_b];

   // the write data comes through the alu and writeback mux
   assert property (@(posedge clk) write_en |-> !$isunknown(wr_data))
      else $error("register write of unknown data to r%0d", addr_s);

endmodule

// ==== src/writeback_unit.sv ====
/*
 * writeback_unit
 * zero test for jz/jnz on register a, and immediate or alu result select
 */
module writeback_unit #(
   parameter int data_width = cpu_pkg::data_width
) (
   input  logic [data_width-1:0]  rd_a,
   input  logic [data_width-1:0]  alu_result,
   input  logic [data_width-1:0]  imm,
   input  logic                   imm_en,
   input  logic                   jz_en,
   input  logic                   jnz_en,
   output logic                   branch_en,
   output logic [data_width-1:0]  result
);

   logic a_zero;

   assign a_zero = (rd_a[7:0] == 8'd0); // only the low byte is tested

   assign branch_en = (jz_en & a_zero) | (jnz_en & ~a_zero);

   assign result = imm_en ? imm : alu_result;

endmodule
